//--- common/icd2_pkg.sv
`default_nettype none

package icd2_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int row_idx_w = 9;   // 512 bytes per row buffer
  localparam int row_cnt   = 4;   // scanline-group buffers
  localparam int pkt_bytes = 16;  // bytes per serial packet
  localparam int pkt_bit_w = 7;   // 128 bit positions per packet
  localparam int pad_cnt   = 4;

  typedef logic [7:0]           byte_t;
  typedef logic [row_idx_w-1:0] row_addr_t;

  // ------------------------------
  // register map
  // ------------------------------
  // compare value is {addr[15:11], 7'h00, addr[3:0]} with bank bit 22 clear
  localparam logic [15:0] reg_lcdc_hw = 16'h6000;  // R hw row / char row
  localparam logic [15:0] reg_lcdc_rd = 16'h6001;  // W read bank select
  localparam logic [15:0] reg_pktrdy  = 16'h6002;  // R packet ready
  localparam logic [15:0] reg_ctl     = 16'h6003;  // W control
  localparam logic [15:0] reg_pad0    = 16'h6004;  // W pads, through 6007
  localparam logic [15:0] reg_ver     = 16'h600F;  // R version
  localparam logic [15:0] reg_pkt     = 16'h7000;  // R packet, through 700F
  localparam logic [15:0] reg_chdat   = 16'h7800;  // R character data

  localparam byte_t ver_value = 8'h61;
  localparam byte_t ctl_reset = 8'h01;  // /20 divisor, core held in reset
  localparam byte_t pad_idle  = 8'hFF;  // active low, nothing pressed

  // ------------------------------
  // clocking
  // ------------------------------
  localparam int skip_period = 737;  // one stalled base clock per period

  // base clocks per cpu clock, indexed by the ctl multiplier code
  localparam logic [5:0] div_cnt [4] = '{6'd16, 6'd20, 6'd28, 6'd36};

  // joypad / serial select-line states
  typedef enum logic [1:0] {
    btn_idle = 2'd0,  // serving pad state
    btn_recv = 2'd1,  // expecting a data bit
    btn_wait = 2'd2,  // expecting 11 between bits
    btn_term = 2'd3   // all 128 bits in, expecting the closing 10
  } btn_state_t;

endpackage

`default_nettype wire

//--- common/row_write_if.sv
`timescale 1ns/1ps
`default_nettype none

// packed byte writes from the pixel packer into the row buffers
interface row_write_if;
  import icd2_pkg::*;

  logic       wr_en;    // one byte per cycle, no back-pressure
  logic [1:0] wr_bank;  // target scanline-group buffer
  row_addr_t  wr_addr;  // {column, line, plane}
  byte_t      wr_data;

  modport packer (
    output wr_en, wr_bank, wr_addr, wr_data
  );

  modport buffers (
    input wr_en, wr_bank, wr_addr, wr_data
  );

endinterface

`default_nettype wire

//--- design/icd2_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module icd2_clock_gen (
  input  logic       CLK,
  input  logic       cpu_ireset_r,  // cold reset
  input  logic       cpu_rst,       // warm reset request from ctl
  input  logic [1:0] clk_mult,      // divisor code from ctl
  output logic       clk_cpu_edge,
  output logic       clk_bus_edge,
  output logic       core_reset_r
);
  import icd2_pkg::*;

  logic [9:0] skip_ctr_r;  // wraps every skip_period base clocks
  logic [5:0] cpu_ctr_r;   // base clocks within one cpu clock
  logic [1:0] bus_ctr_r;   // cpu edges within one bus clock
  logic [1:0] mult_r;      // divisor in use, only moves on a bus edge
  logic       skip_hit;
  logic       cpu_hit;

  // ------------------------------
  // base clock to cpu edge
  // ------------------------------
  assign skip_hit = (skip_ctr_r == 10'(skip_period - 1));
  // the skip clock is absorbed by stalling the cpu counter
  assign cpu_hit  = ~skip_hit & (cpu_ctr_r == div_cnt[mult_r] - 6'd1);

  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      skip_ctr_r   <= '0;
      cpu_ctr_r    <= '0;
      clk_cpu_edge <= 1'b0;
    end else begin
      skip_ctr_r <= skip_hit ? 10'd0 : skip_ctr_r + 10'd1;
      if (!skip_hit) begin
        cpu_ctr_r <= cpu_hit ? 6'd0 : cpu_ctr_r + 6'd1;
      end
      clk_cpu_edge <= cpu_hit;  // registered, one base clock wide
    end
  end

  // ------------------------------
  // bus edge, divisor sync, warm reset
  // ------------------------------
  assign clk_bus_edge = clk_cpu_edge & (&bus_ctr_r);  // every 4th cpu edge

  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      bus_ctr_r <= '0;
    end else if (clk_cpu_edge) begin
      bus_ctr_r <= bus_ctr_r + 2'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (cpu_ireset_r || clk_bus_edge) mult_r <= clk_mult;  // no mid-bus-clock change
  end

  // held until the first bus edge after both resets drop
  always_ff @(posedge CLK) begin
    core_reset_r <= cpu_ireset_r | cpu_rst | (core_reset_r & ~clk_bus_edge);
  end

endmodule

`default_nettype wire

//--- design/row_buffers/icd2_row_buffers.sv
`timescale 1ns/1ps
`default_nettype none

module icd2_row_buffers (
  input  logic                CLK,
  row_write_if.buffers        wr,
  input  logic [1:0]          rd_bank,
  input  icd2_pkg::row_addr_t rd_addr,
  output icd2_pkg::byte_t     rd_data
);
  import icd2_pkg::*;

  byte_t      rd_q [row_cnt];  // registered read of every bank
  logic [1:0] rd_bank_r;       // select lines up with rd_q

  // one inferred single-clock ram per scanline group
  for (genvar b = 0; b < row_cnt; b++) begin : g_bank
    byte_t mem [2**row_idx_w];

    always_ff @(posedge CLK) begin
      if (wr.wr_en && wr.wr_bank == 2'(b)) begin
        mem[wr.wr_addr] <= wr.wr_data;
      end
      rd_q[b] <= mem[rd_addr];  // read before write on a collision
    end
  end

  always_ff @(posedge CLK) begin
    rd_bank_r <= rd_bank;
  end

  assign rd_data = rd_q[rd_bank_r];

endmodule

`default_nettype wire

//--- design/icd2_pixel_packer.sv
`timescale 1ns/1ps
`default_nettype none

module icd2_pixel_packer (
  input  logic            CLK,
  input  logic            core_reset_r,
  input  logic            ppu_dot_edge,
  input  logic            ppu_pixel_valid,
  input  logic            ppu_vsync_edge,
  input  logic            ppu_hsync_edge,
  input  logic [1:0]      ppu_pixel,
  row_write_if.packer     wr,
  output icd2_pkg::byte_t lcdc_hw           // [7:3] char row, [1:0] write bank
);
  import icd2_pkg::*;

  logic [2:0] pix_cnt_r;   // pixel within the current 8-pixel tile row
  logic [4:0] col_r;       // character column, 20 per line
  logic [2:0] line_r;      // line within the character row
  byte_t      plane_r [2]; // planar bytes being filled
  logic [7:0] wr_base_r;   // {col, line} of the completed tile row
  logic [1:0] wr_phase_r;  // 01 writes plane 0, 10 writes plane 1
  byte_t      lcdc_r;
  logic       pix_last;
  logic       row_full;

  assign pix_last = ppu_dot_edge & ppu_pixel_valid & (&pix_cnt_r);
  assign row_full = lcdc_r[7] & lcdc_r[4];  // char row 18 reached

  // ------------------------------
  // write path
  // ------------------------------
  assign wr.wr_en   = |wr_phase_r;
  assign wr.wr_bank = lcdc_r[1:0];
  assign wr.wr_addr = {wr_base_r, wr_phase_r[1]};  // even then odd
  assign wr.wr_data = plane_r[wr_phase_r[1]];
  assign lcdc_hw    = lcdc_r;

  // ------------------------------
  // position tracking
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (core_reset_r) begin
      pix_cnt_r  <= '0;
      col_r      <= '0;
      line_r     <= '0;
      wr_phase_r <= '0;
      lcdc_r     <= '0;
    end else begin
      wr_phase_r <= {wr_phase_r[0], 1'b0};
      if (ppu_dot_edge) begin
        if (ppu_pixel_valid) begin
          pix_cnt_r <= pix_cnt_r + 3'd1;
          if (pix_last) begin
            col_r      <= col_r + 5'd1;
            wr_phase_r <= 2'b01;  // two writes in the next two clocks
          end
        end else if (ppu_vsync_edge) begin
          pix_cnt_r   <= '0;
          col_r       <= '0;
          lcdc_r[7:3] <= '0;
        end else if (ppu_hsync_edge && !row_full) begin
          line_r <= line_r + 3'd1;
          col_r  <= '0;
          if (&line_r) begin  // 8 lines done, next group
            lcdc_r[1:0] <= lcdc_r[1:0] + 2'd1;
            lcdc_r[7:3] <= lcdc_r[7:3] + 5'd1;
          end
        end
      end
    end
  end

  // ------------------------------
  // planar packing
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (ppu_dot_edge && ppu_pixel_valid) begin
      plane_r[1][3'd7 - pix_cnt_r] <= ppu_pixel[1];  // msb first in each plane
      plane_r[0][3'd7 - pix_cnt_r] <= ppu_pixel[0];
      if (&pix_cnt_r) wr_base_r <= {col_r, line_r};
    end
  end

endmodule

`default_nettype wire

//--- design/icd2_mmio_regs.sv
`timescale 1ns/1ps
`default_nettype none

module icd2_mmio_regs (
  input  logic                CLK,
  input  logic                cpu_ireset_r,
  input  logic                core_reset_r,
  input  logic                snes_rd_start,
  input  logic                snes_wr_end,
  input  logic [23:0]         snes_addr,
  input  icd2_pkg::byte_t     data_in,
  output icd2_pkg::byte_t     data_out,
  input  icd2_pkg::byte_t     lcdc_hw,
  input  icd2_pkg::byte_t     pkt_bytes [icd2_pkg::pkt_bytes],
  input  logic                pkt_ready,
  input  icd2_pkg::byte_t     rd_data,
  output logic [1:0]          rd_bank,
  output icd2_pkg::row_addr_t rd_addr,
  output icd2_pkg::byte_t     pad [icd2_pkg::pad_cnt],
  output logic [1:0]          player_mask,
  output logic [1:0]          clk_mult,
  output logic                cpu_rst,
  output logic                pkt_read_clear
);
  import icd2_pkg::*;

  logic [15:0] key;         // folded register address
  logic        hit;         // bank bit selects the register window
  logic        rd_hit;
  logic        wr_hit;
  logic        pkt_hit;     // 7000-700F
  byte_t       ctl_r;
  byte_t       chdat_r;     // second stage of the char data read
  byte_t       data_out_r;
  logic [1:0]  rd_bank_r;
  row_addr_t   rd_idx_r;

  assign key     = {snes_addr[15:11], 7'h00, snes_addr[3:0]};
  assign hit     = ~snes_addr[22];
  assign rd_hit  = snes_rd_start & hit;
  assign wr_hit  = snes_wr_end & hit;
  assign pkt_hit = (key[15:4] == reg_pkt[15:4]);

  assign data_out       = data_out_r;
  assign rd_bank        = rd_bank_r;
  assign rd_addr        = rd_idx_r;
  assign cpu_rst        = ~ctl_r[7];
  assign player_mask    = ctl_r[5:4];
  assign clk_mult       = ctl_r[1:0];
  assign pkt_read_clear = rd_hit & (key == reg_pkt);  // reading byte 0 acks

  // ------------------------------
  // ctl, cold reset only
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (cpu_ireset_r) begin
      ctl_r <= ctl_reset;
    end else if (wr_hit && key == reg_ctl) begin
      ctl_r <= {data_in[7], 1'b0, data_in[5:4], 2'b00, data_in[1:0]};
    end
  end

  // ------------------------------
  // pads and char read pointer
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (core_reset_r) begin
      rd_bank_r <= '0;
      rd_idx_r  <= '0;
      for (int i = 0; i < pad_cnt; i++) pad[i] <= pad_idle;
    end else begin
      if (wr_hit && key == reg_lcdc_rd) begin
        rd_bank_r <= data_in[1:0];
        rd_idx_r  <= '0;  // restart at the top of the buffer
      end
      if (wr_hit && key[15:2] == reg_pad0[15:2]) pad[key[1:0]] <= data_in;
      if (rd_hit && key == reg_chdat) rd_idx_r <= rd_idx_r + 1'b1;
      // pads outside the player mask never report a press
      for (int i = 0; i < pad_cnt; i++) begin
        if ((2'(i) & ~player_mask) != 2'b00) pad[i] <= pad_idle;
      end
    end
  end

  // ------------------------------
  // read data latch
  // ------------------------------
  // latched at read start so late writes cannot disturb the bus
  always_ff @(posedge CLK) begin
    chdat_r <= rd_data;
    if (rd_hit) begin
      if (pkt_hit) begin
        data_out_r <= pkt_bytes[key[3:0]];
      end else begin
        case (key)
          reg_lcdc_hw: data_out_r <= lcdc_hw;
          reg_pktrdy:  data_out_r <= {7'd0, pkt_ready};
          reg_ver:     data_out_r <= ver_value;
          reg_chdat:   data_out_r <= chdat_r;
          default:     data_out_r <= data_out_r;  // write-only or unmapped
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- design/icd2_joypad_link.sv
`timescale 1ns/1ps
`default_nettype none

module icd2_joypad_link (
  input  logic            CLK,
  input  logic            core_reset_r,
  input  logic            clk_cpu_edge,
  input  logic [1:0]      p1i,            // select lines from the handheld
  output logic [3:0]      p1o,            // active-low key lines back
  output logic            idl,
  input  icd2_pkg::byte_t pad [icd2_pkg::pad_cnt],
  input  logic [1:0]      player_mask,
  input  logic            pkt_read_clear,
  output icd2_pkg::byte_t pkt_bytes [icd2_pkg::pkt_bytes],
  output logic            pkt_ready
);
  import icd2_pkg::*;

  btn_state_t           state_r;
  logic [1:0]           prev_r;     // p1i at the previous cpu edge
  logic [1:0]           id_r;       // pad currently served
  logic [pkt_bit_w-1:0] bit_pos_r;  // next packet bit, lsb first
  logic                 p1i_chg;
  byte_t                cur_pad;

  assign p1i_chg = clk_cpu_edge & (p1i != prev_r);
  assign cur_pad = pad[id_r];
  assign idl     = (state_r == btn_idle);

  // ------------------------------
  // pad output
  // ------------------------------
  // 11 reports the id, 01 the buttons, 10 the d-pad
  always_comb begin
    if (p1i == 2'b11) begin
      p1o = ~{2'b00, id_r};
    end else begin
      p1o = ({4{p1i[1]}} | cur_pad[7:4]) & ({4{p1i[0]}} | cur_pad[3:0]);
    end
  end

  // ------------------------------
  // select-line FSM
  // ------------------------------
  always_ff @(posedge CLK) begin
    if (core_reset_r) begin
      state_r   <= btn_idle;
      prev_r    <= 2'b11;
      id_r      <= '0;
      bit_pos_r <= '0;
      pkt_ready <= 1'b0;
    end else begin
      if (pkt_read_clear) pkt_ready <= 1'b0;  // a set in the same cycle wins below
      if (clk_cpu_edge) prev_r <= p1i;
      if (p1i_chg) begin
        if (p1i == 2'b00) begin
          // 00 from anywhere starts a new packet
          bit_pos_r <= '0;
          state_r   <= btn_wait;
        end else begin
          case (state_r)
            btn_idle: begin
              if (!prev_r[1] && p1i[1]) id_r <= (id_r + 2'd1) & player_mask;
            end
            btn_recv: begin
              if (^p1i) begin
                pkt_bytes[bit_pos_r[6:3]][bit_pos_r[2:0]] <= p1i[0];
                bit_pos_r <= bit_pos_r + 1'b1;
                state_r   <= (&bit_pos_r) ? btn_term : btn_wait;
              end
            end
            btn_wait: begin
              // 11 separates bits, a stray 10 or 01 drops the packet
              state_r <= (p1i == 2'b11) ? btn_recv : btn_idle;
            end
            btn_term: begin
              if (p1i == 2'b10) begin
                pkt_ready <= 1'b1;
                state_r   <= btn_idle;
              end else if (p1i == 2'b01) begin
                state_r <= btn_idle;
              end
            end
            default: state_r <= btn_idle;
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- design/sgb_icd2.sv
`timescale 1ns/1ps
`default_nettype none

module sgb_icd2 (
  input  logic            CLK,
  input  logic            cpu_ireset_r,
  output logic            clk_cpu_edge,
  output logic            cpu_rst,

  // console cartridge bus
  input  logic            snes_rd_start,
  input  logic            snes_wr_end,
  input  logic [23:0]     snes_addr,
  input  icd2_pkg::byte_t data_in,
  output icd2_pkg::byte_t data_out,

  // handheld pixel stream
  input  logic            ppu_dot_edge,
  input  logic            ppu_pixel_valid,
  input  logic [1:0]      ppu_pixel,
  input  logic            ppu_vsync_edge,
  input  logic            ppu_hsync_edge,

  // joypad / serial
  input  logic [1:0]      p1i,
  output logic [3:0]      p1o,
  output logic            idl
);
  import icd2_pkg::*;

  logic       core_reset_r;
  logic [1:0] clk_mult;
  logic [1:0] player_mask;
  logic       pkt_read_clear;
  logic       pkt_ready;
  logic [1:0] rd_bank;
  row_addr_t  rd_addr;
  byte_t      rd_data;
  byte_t      lcdc_hw;
  byte_t      pad [pad_cnt];
  byte_t      pkt_bytes [icd2_pkg::pkt_bytes];

  row_write_if row_wr ();

  icd2_clock_gen clock_gen_i (
    .CLK          (CLK),
    .cpu_ireset_r (cpu_ireset_r),
    .cpu_rst      (cpu_rst),
    .clk_mult     (clk_mult),
    .clk_cpu_edge (clk_cpu_edge),
    .clk_bus_edge (),              // only used inside the clock generator
    .core_reset_r (core_reset_r)
  );

  icd2_mmio_regs mmio_i (
    .CLK            (CLK),
    .cpu_ireset_r   (cpu_ireset_r),
    .core_reset_r   (core_reset_r),
    .snes_rd_start  (snes_rd_start),
    .snes_wr_end    (snes_wr_end),
    .snes_addr      (snes_addr),
    .data_in        (data_in),
    .data_out       (data_out),
    .lcdc_hw        (lcdc_hw),
    .pkt_bytes      (pkt_bytes),
    .pkt_ready      (pkt_ready),
    .rd_data        (rd_data),
    .rd_bank        (rd_bank),
    .rd_addr        (rd_addr),
    .pad            (pad),
    .player_mask    (player_mask),
    .clk_mult       (clk_mult),
    .cpu_rst        (cpu_rst),
    .pkt_read_clear (pkt_read_clear)
  );

  icd2_pixel_packer packer_i (
    .CLK             (CLK),
    .core_reset_r    (core_reset_r),
    .ppu_dot_edge    (ppu_dot_edge),
    .ppu_pixel_valid (ppu_pixel_valid),
    .ppu_vsync_edge  (ppu_vsync_edge),
    .ppu_hsync_edge  (ppu_hsync_edge),
    .ppu_pixel       (ppu_pixel),
    .wr              (row_wr.packer),
    .lcdc_hw         (lcdc_hw)
  );

  icd2_row_buffers row_buffers_i (
    .CLK     (CLK),
    .wr      (row_wr.buffers),
    .rd_bank (rd_bank),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  icd2_joypad_link joypad_i (
    .CLK            (CLK),
    .core_reset_r   (core_reset_r),
    .clk_cpu_edge   (clk_cpu_edge),
    .p1i            (p1i),
    .p1o            (p1o),
    .idl            (idl),
    .pad            (pad),
    .player_mask    (player_mask),
    .pkt_read_clear (pkt_read_clear),
    .pkt_bytes      (pkt_bytes),
    .pkt_ready      (pkt_ready)
  );

endmodule

`default_nettype wire

//--- verification/icd2_tb_tasks.svh
// ------------------------------
// checking
// ------------------------------
task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  checks++;
  if (got !== exp) begin
    $display("mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    test_errs++;
  end
endtask

task automatic abort_run(input string why);
  $display("%s", why);
  $display("TEST FAILED");
  $finish;
endtask

// ------------------------------
// console bus
// ------------------------------
task automatic bus_write(input logic [15:0] addr, input byte_t val);
  @(posedge CLK);
  snes_addr   <= {8'h00, addr};  // bank bit 22 clear
  data_in     <= val;
  snes_wr_end <= 1'b1;
  @(posedge CLK);
  snes_wr_end <= 1'b0;
  @(posedge CLK);  // idle cycle so the next read sees the new pointer
endtask

task automatic bus_read(input logic [15:0] addr, output byte_t val);
  @(posedge CLK);
  snes_addr     <= {8'h00, addr};
  snes_rd_start <= 1'b1;
  @(posedge CLK);
  snes_rd_start <= 1'b0;
  repeat (2) @(posedge CLK);  // keeps 7800 reads 4 cycles apart
  val = data_out;
endtask

task automatic read_expect(input logic [15:0] addr, input byte_t exp, input string name);
  byte_t got;
  bus_read(addr, got);
  check_val(name, got, exp);
endtask

// ------------------------------
// handheld side drivers
// ------------------------------
// returns the base clocks since the previous call saw an edge
task automatic wait_cpu_edge(output int cycles);
  cycles = 0;
  do begin
    @(posedge CLK);
    cycles++;
  end while (!clk_cpu_edge && cycles < edge_limit);
  if (!clk_cpu_edge) abort_run("timeout: no cpu clock edge within the limit");
endtask

task automatic set_sel(input logic [1:0] sel);
  int c;
  @(posedge CLK);
  p1i <= sel;
  wait_cpu_edge(c);  // link only looks at p1i on a cpu edge
  @(posedge CLK);
endtask

task automatic send_dot(input logic valid, input logic [1:0] px, input logic vs, input logic hs);
  @(posedge CLK);
  ppu_dot_edge    <= 1'b1;
  ppu_pixel_valid <= valid;
  ppu_pixel       <= px;
  ppu_vsync_edge  <= vs;
  ppu_hsync_edge  <= hs;
  @(posedge CLK);
  ppu_dot_edge    <= 1'b0;
  ppu_pixel_valid <= 1'b0;
  ppu_vsync_edge  <= 1'b0;
  ppu_hsync_edge  <= 1'b0;
  repeat (2) @(posedge CLK);  // dots are a few base clocks apart
endtask

// ------------------------------
// reference models
// ------------------------------
function automatic int base_clocks_per_cpu(input int code);
  case (code)
    0:       return 16;
    1:       return 20;
    2:       return 28;
    default: return 36;
  endcase
endfunction

// px holds 8 pixels, leftmost in bits 1:0; leftmost pixel lands in bit 7
function automatic byte_t pack_plane(input logic [15:0] px, input int plane);
  byte_t b;
  for (int i = 0; i < 8; i++) b[7-i] = px[2*i+plane];
  return b;
endfunction

// active low lines, a high select line hides its nibble
function automatic logic [3:0] pad_lines(input byte_t pad_byte, input logic [1:0] sel,
                                         input logic [1:0] id);
  logic [3:0] btn;
  logic [3:0] dir;
  if (sel == 2'b11) return ~{2'b00, id};
  btn = sel[1] ? 4'hF : pad_byte[7:4];
  dir = sel[0] ? 4'hF : pad_byte[3:0];
  return btn & dir;
endfunction

function automatic byte_t pad_seen(input byte_t written, input logic [1:0] idx,
                                   input logic [1:0] mask);
  return ((idx & ~mask) != 2'b00) ? pad_idle : written;  // unused pad reads idle
endfunction

function automatic logic [1:0] next_id(input btn_state_t st, input logic [1:0] prev,
                                       input logic [1:0] sel, input logic [1:0] id,
                                       input logic [1:0] mask);
  if (st == btn_idle && !prev[1] && sel[1]) return (id + 2'd1) & mask;
  return id;
endfunction

// bit n of the packet, lsb of byte 0 first, carried on p1i[0]
function automatic logic [1:0] bit_sel(input logic [127:0] pkt, input int n);
  return pkt[n] ? 2'b01 : 2'b10;
endfunction

//--- verification/tb_icd2.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icd2;
  import icd2_pkg::*;

  localparam int edge_limit = 64;  // longest cpu clock is 37 base clocks

  logic        CLK;
  logic        cpu_ireset_r;
  logic        clk_cpu_edge;
  logic        cpu_rst;
  logic        snes_rd_start;
  logic        snes_wr_end;
  logic [23:0] snes_addr;
  byte_t       data_in;
  byte_t       data_out;
  logic        ppu_dot_edge;
  logic        ppu_pixel_valid;
  logic [1:0]  ppu_pixel;
  logic        ppu_vsync_edge;
  logic        ppu_hsync_edge;
  logic [1:0]  p1i;
  logic [3:0]  p1o;
  logic        idl;

  int seed = 32'h0ac9983b;
  int checks;
  int test_errs;
  int total_errs;
  int tests_run;
  int tests_failed;

  sgb_icd2 dut_i (
    .CLK             (CLK),
    .cpu_ireset_r    (cpu_ireset_r),
    .clk_cpu_edge    (clk_cpu_edge),
    .cpu_rst         (cpu_rst),
    .snes_rd_start   (snes_rd_start),
    .snes_wr_end     (snes_wr_end),
    .snes_addr       (snes_addr),
    .data_in         (data_in),
    .data_out        (data_out),
    .ppu_dot_edge    (ppu_dot_edge),
    .ppu_pixel_valid (ppu_pixel_valid),
    .ppu_pixel       (ppu_pixel),
    .ppu_vsync_edge  (ppu_vsync_edge),
    .ppu_hsync_edge  (ppu_hsync_edge),
    .p1i             (p1i),
    .p1o             (p1o),
    .idl             (idl)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;  // 100 ns base clock
  end

  `include "icd2_tb_tasks.svh"

  task automatic report_test(input string name);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    $display("test %0d %s: %s, %0d mismatches", tests_run, name,
             (test_errs == 0) ? "pass" : "fail", test_errs);
    total_errs += test_errs;
    test_errs = 0;
  endtask

  // ------------------------------
  // tests
  // ------------------------------
  task automatic reset_values();
    read_expect(reg_ver, ver_value, "data_out @600f");
    read_expect(reg_pktrdy, 8'h00, "data_out @6002");
    @(posedge CLK);
    check_val("p1o", p1o, pad_lines(pad_idle, 2'b11, 2'd0));  // core still held so id is 0
    check_val("idl", idl, 1'b1);
    check_val("cpu_rst", cpu_rst, 1'b1);  // ctl bit 7 clear after cold reset
    report_test("reset values");
  endtask

  task automatic divisor_sweep();
    int n;
    int gap;
    for (int code = 0; code < 4; code++) begin
      n = base_clocks_per_cpu(code);
      bus_write(reg_ctl, {6'b100000, code[1:0]});  // bit 7 releases the core
      check_val("cpu_rst", cpu_rst, 1'b0);
      repeat (12) wait_cpu_edge(gap);               // 3 bus edges so the new divisor is in use
      for (int k = 0; k < 30; k++) begin
        wait_cpu_edge(gap);
        // one interval in 737 clocks carries the skip clock
        check_val($sformatf("cpu edge gap /%0d", n), gap, (gap == n + 1) ? n + 1 : n);
      end
    end
    report_test("clock divisor");
  endtask

  task automatic pad_select();
    byte_t      pads [pad_cnt];
    logic [1:0] mask;
    logic [1:0] id;
    logic [1:0] prev;
    logic [1:0] sel;
    int         rnd;
    id   = 2'd0;   // select lines unchanged since core reset
    prev = 2'b11;
    for (int pass = 0; pass < 2; pass++) begin
      rnd  = $random(seed);
      mask = rnd[5:4];
      bus_write(reg_ctl, {2'b10, mask, 4'b0000});  // fastest divisor
      for (int i = 0; i < pad_cnt; i++) begin
        rnd     = $random(seed);
        pads[i] = rnd[7:0];
        bus_write({reg_pad0[15:2], i[1:0]}, pads[i]);
      end
      for (int r = 0; r < 6; r++) begin
        for (int s = 0; s < 3; s++) begin
          sel = (s == 0) ? 2'b01 : (s == 1) ? 2'b10 : 2'b11;
          set_sel(sel);
          id   = next_id(btn_idle, prev, sel, id, mask);
          prev = sel;
          check_val($sformatf("p1o sel %b", sel), p1o,
                    pad_lines(pad_seen(pads[id], id, mask), sel, id));
        end
      end
    end
    report_test("pad output");
  endtask

  task automatic serial_packet();
    logic [127:0] pkt;
    int           rnd;
    for (int i = 0; i < 4; i++) begin
      rnd = $random(seed);
      pkt[32*i +: 32] = rnd;
    end
    set_sel(2'b00);  // packet start
    set_sel(2'b11);
    for (int n = 0; n < 128; n++) begin
      set_sel(bit_sel(pkt, n));
      set_sel(2'b11);
    end
    set_sel(2'b10);  // closing pulse
    read_expect(reg_pktrdy, 8'h01, "data_out @6002");
    for (int i = 0; i < pkt_bytes; i++) begin
      read_expect({reg_pkt[15:4], i[3:0]}, pkt[8*i +: 8], $sformatf("data_out @700%0h", i));
    end
    read_expect(reg_pktrdy, 8'h00, "data_out @6002 after 7000");
    // 127 bits go in and then 01 arrives where 11 belongs
    set_sel(2'b11);
    set_sel(2'b00);
    set_sel(2'b11);
    for (int n = 0; n < 126; n++) begin
      set_sel(bit_sel(pkt, n));
      set_sel(2'b11);
    end
    set_sel(2'b10);  // bit 126 leaves the link in wait
    set_sel(2'b01);  // stray select where 11 belongs
    set_sel(2'b11);
    set_sel(2'b10);  // would be bit 127
    set_sel(2'b11);
    set_sel(2'b10);  // would close the packet
    read_expect(reg_pktrdy, 8'h00, "data_out @6002 after abort");
    check_val("idl", idl, 1'b1);
    set_sel(2'b11);
    report_test("serial packet");
  endtask

  task automatic pixel_rows();
    logic [1:0]  pix [8*160];
    logic [15:0] grp;
    int          rnd;
    int          col;
    int          ln;
    send_dot(1'b0, 2'b00, 1'b1, 1'b0);  // vsync leaves the write bank alone
    for (int l = 0; l < 8; l++) begin
      for (int x = 0; x < 160; x++) begin
        rnd = $random(seed);
        pix[l*160+x] = rnd[1:0];
        send_dot(1'b1, rnd[1:0], 1'b0, 1'b0);
      end
      send_dot(1'b0, 2'b00, 1'b0, 1'b1);  // hsync
    end
    read_expect(reg_lcdc_hw, {5'd1, 1'b0, 2'd1}, "data_out @6000");  // char row 1 in bank 1
    bus_write(reg_lcdc_rd, 8'h00);
    for (int a = 0; a < 320; a++) begin
      col = a / 16;
      ln  = (a / 2) % 8;
      for (int i = 0; i < 8; i++) grp[2*i +: 2] = pix[ln*160 + col*8 + i];
      read_expect(reg_chdat, pack_plane(grp, a % 2), $sformatf("data_out @7800 [%0d]", a));
    end
    report_test("pixel rows");
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    checks          = 0;
    test_errs       = 0;
    total_errs      = 0;
    tests_run       = 0;
    tests_failed    = 0;
    cpu_ireset_r    <= 1'b1;
    snes_rd_start   <= 1'b0;
    snes_wr_end     <= 1'b0;
    snes_addr       <= '0;
    data_in         <= '0;
    ppu_dot_edge    <= 1'b0;
    ppu_pixel_valid <= 1'b0;
    ppu_pixel       <= 2'b00;
    ppu_vsync_edge  <= 1'b0;
    ppu_hsync_edge  <= 1'b0;
    p1i             <= 2'b11;  // nothing selected
    repeat (10) @(posedge CLK);
    cpu_ireset_r <= 1'b0;
    reset_values();
    divisor_sweep();
    pad_select();
    serial_packet();
    pixel_rows();
    $display("%0d tests, %0d failed, %0d checks, %0d mismatches",
             tests_run, tests_failed, checks, total_errs);
    if (tests_failed == 0 && total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
+incdir+verification
common/icd2_pkg.sv
common/row_write_if.sv
design/icd2_clock_gen.sv
design/row_buffers/icd2_row_buffers.sv
design/icd2_pixel_packer.sv
design/icd2_mmio_regs.sv
design/icd2_joypad_link.sv
design/sgb_icd2.sv
verification/tb_icd2.sv

//--- Bender.yml
package:
  name: sgb_icd2

sources:
  - files:
      - common/icd2_pkg.sv
      - common/row_write_if.sv
      - design/icd2_clock_gen.sv
      - design/row_buffers/icd2_row_buffers.sv
      - design/icd2_pixel_packer.sv
      - design/icd2_mmio_regs.sv
      - design/icd2_joypad_link.sv
      - design/sgb_icd2.sv
  - target: simulation
    include_dirs:
      - verification
    files:
      - verification/tb_icd2.sv
